//--- vlog.f
hdl/dbg_pkg.sv
hdl/cpu_pkg.sv
hdl/uart.sv
hdl/debug_unit.sv
hdl/data_path.sv
hdl/top.sv
dv/top_sva.sv
dv/tb_top.sv

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import dbg_pkg::*;
    import cpu_pkg::*;

    localparam int BIT_WAIT = 20 * CLKS_PER_BIT;  // Reply timeout in clocks

    logic        clock = 1'b0;
    logic        rst = 1'b1;
    logic        uart_rx = 1'b1;
    logic        uart_tx;
    logic        hlt;
    du_state_e   state;

    logic [31:0] prog [IM_WORDS];
    int          prog_len;
    logic [31:0] ref_imem [IM_WORDS];
    logic [31:0] ref_regs [NREGS];
    logic [31:0] ref_dm [DM_WORDS];
    logic [31:0] ref_pc;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          sva_fails;

    top DUT (
        .i_clock(clock),
        .i_rst(rst),
        .i_uart_rx(uart_rx),
        .o_uart_tx(uart_tx),
        .o_hlt(hlt),
        .o_state(state)
    );

    always #5 clock = ~clock;

    function automatic logic [31:0] enc_r(input logic [3:0] op, input logic [2:0] rd,
                                          input logic [2:0] rs, input logic [2:0] rt);
        instr_u w;
        w = '0;
        w.r.op = op;
        w.r.rd = rd;
        w.r.rs = rs;
        w.r.rt = rt;
        return w;
    endfunction

    function automatic logic [31:0] enc_i(input logic [3:0] op, input logic [2:0] rd,
                                          input logic [2:0] rs, input logic [15:0] imm);
        instr_u w;
        w = '0;
        w.i.op  = op;
        w.i.rd  = rd;
        w.i.rs  = rs;
        w.i.imm = imm;
        return w;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp_val);
        assert (got === exp_val) else begin
            $display("Error: %s = %h, expected %h", name, got, exp_val);
            errors++;
        end
    endtask

    // Host side of the serial link, 8N1
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        @(posedge clock);
        #1;
        for (int k = 0; k < 10; k++) begin
            uart_rx = frame[k];
            repeat (CLKS_PER_BIT) @(posedge clock);
            #1;
        end
    endtask

    task automatic recv_byte(output logic [7:0] b);
        int waited;
        waited = 0;
        b = 'x;
        @(negedge clock);
        while (uart_tx === 1'b1 && waited < BIT_WAIT) begin
            @(negedge clock);
            waited++;
        end
        assert (uart_tx === 1'b0) else begin
            $display("No start bit from the DUT within %0d clocks", BIT_WAIT);
            errors++;
        end
        if (uart_tx === 1'b0) begin
            repeat (CLKS_PER_BIT / 2 - 1) @(negedge clock);  // Near mid start bit
            for (int k = 0; k < 8; k++) begin
                repeat (CLKS_PER_BIT) @(negedge clock);
                b[k] = uart_tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clock);
            assert (uart_tx === 1'b1) else begin
                $display("Stop bit missing on the DUT serial output");
                errors++;
            end
        end
    endtask

    // Reply may start before the host stop bit ends
    task automatic exchange(input logic [7:0] cmd, output logic [7:0] rsp);
        fork
            send_byte(cmd);
            recv_byte(rsp);
        join
    endtask

    task automatic command(input logic [7:0] cmd, input logic [7:0] exp_rsp);
        logic [7:0] rsp;
        exchange(cmd, rsp);
        check_val("reply", rsp, exp_rsp);
    endtask

    task automatic reset_all();
        @(posedge clock);
        #1;
        rst     = 1'b1;
        uart_rx = 1'b1;
        repeat (10) @(posedge clock);
        #1;
        rst    = 1'b0;
        ref_pc = '0;
        for (int k = 0; k < NREGS; k++) begin
            ref_regs[k] = '0;
        end
        for (int k = 0; k < DM_WORDS; k++) begin
            ref_dm[k] = '0;
        end
    endtask

    task automatic load_program();
        int nbytes;
        nbytes = prog_len * 4;
        send_byte(CMD_LOAD);
        send_byte(8'(nbytes));
        for (int k = 0; k < nbytes - 1; k++) begin
            send_byte(prog[k / 4][(k % 4) * 8 +: 8]);  // Little endian
        end
        command(prog[prog_len - 1][31:24], RSP_OK);
        for (int k = 0; k < prog_len; k++) begin
            ref_imem[k] = prog[k];
        end
    endtask

    task automatic ref_step();
        instr_u      w;
        logic [31:0] addr;
        w    = ref_imem[ref_pc[5:0]];
        addr = ref_regs[w.i.rs] + {{16{w.i.imm[15]}}, w.i.imm};
        case (w.r.op)
            OP_ADD:  ref_regs[w.r.rd] = ref_regs[w.r.rs] + ref_regs[w.r.rt];
            OP_SUB:  ref_regs[w.r.rd] = ref_regs[w.r.rs] - ref_regs[w.r.rt];
            OP_ADDI: ref_regs[w.i.rd] = addr;
            OP_LW:   ref_regs[w.i.rd] = ref_dm[addr[2:0]];
            OP_SW:   ref_dm[addr[2:0]] = ref_regs[w.i.rd];
            default: ;
        endcase
        if (w.r.op != OP_HALT) begin
            ref_pc = ref_pc + 1;
        end
    endtask

    task automatic ref_run();
        int n;
        n = 0;
        while (ref_imem[ref_pc[5:0]][31:28] != OP_HALT && n < 1000) begin
            ref_step();
            n++;
        end
    endtask

    task automatic dump_check();
        logic [7:0]  b;
        logic [31:0] word;
        logic [31:0] exp_val;
        string       name;
        for (int w = 0; w < DUMP_WORDS; w++) begin
            for (int k = 0; k < 4; k++) begin
                if (w == 0 && k == 0) begin
                    exchange(CMD_DUMP, b);
                end else begin
                    recv_byte(b);
                end
                word[k * 8 +: 8] = b;
            end
            if (w == 0) begin
                exp_val = ref_pc;
                name    = "dump pc";
            end else if (w <= NREGS) begin
                exp_val = ref_regs[w - 1];
                name    = $sformatf("dump r%0d", w - 1);
            end else begin
                exp_val = ref_dm[w - 1 - NREGS];
                name    = $sformatf("dump dm%0d", w - 1 - NREGS);
            end
            check_val(name, word, exp_val);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: FAIL, %0d errors", tests_run, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    task automatic test_reset_state();
        reset_all();
        @(negedge clock);
        check_val("o_uart_tx", uart_tx, 1'b1);
        check_val("o_hlt", hlt, 1'b0);
        check_val("o_state", state, IDLE);
        dump_check();
        end_test("reset_state");
    endtask

    task automatic test_load();
        reset_all();
        prog[0]  = enc_i(OP_ADDI, 3'd1, 3'd0, 16'd5);
        prog[1]  = enc_i(OP_ADDI, 3'd2, 3'd0, 16'hfffd);  // -3
        prog[2]  = enc_r(OP_ADD, 3'd3, 3'd1, 3'd2);
        prog[3]  = enc_r(OP_SUB, 3'd4, 3'd1, 3'd2);
        prog[4]  = enc_r(OP_HALT, 3'd0, 3'd0, 3'd0);
        prog_len = 5;
        load_program();
        dump_check();
        end_test("load");
    endtask

    task automatic test_step();
        reset_all();
        command(CMD_STEP, RSP_OK);
        ref_step();
        command(CMD_STEP, RSP_OK);
        ref_step();
        dump_check();
        end_test("step");
    endtask

    task automatic test_run();
        reset_all();
        prog[0]  = enc_i(OP_ADDI, 3'd1, 3'd0, 16'd7);
        prog[1]  = enc_i(OP_ADDI, 3'd2, 3'd0, 16'd20);
        prog[2]  = enc_r(OP_ADD, 3'd3, 3'd1, 3'd2);
        prog[3]  = enc_r(OP_SUB, 3'd4, 3'd2, 3'd1);
        prog[4]  = enc_i(OP_SW, 3'd3, 3'd0, 16'd2);
        prog[5]  = enc_i(OP_SW, 3'd4, 3'd1, 16'hfffc);  // Address 7 - 4
        prog[6]  = enc_i(OP_LW, 3'd5, 3'd0, 16'd2);
        prog[7]  = enc_i(OP_ADDI, 3'd6, 3'd5, 16'hff9c);
        prog[8]  = enc_i(OP_ADDI, 3'd0, 3'd4, 16'd1);
        prog[9]  = enc_i(OP_LW, 3'd7, 3'd1, 16'hfffc);
        prog[10] = enc_r(OP_HALT, 3'd0, 3'd0, 3'd0);
        prog_len = 11;
        load_program();
        command(CMD_RUN, RSP_HALT);
        ref_run();
        @(negedge clock);
        check_val("o_hlt", hlt, 1'b1);
        dump_check();
        end_test("run");
    endtask

    task automatic test_step_halted();
        reset_all();
        command(CMD_RUN, RSP_HALT);
        ref_run();
        command(CMD_STEP, RSP_OK);
        dump_check();
        end_test("step_halted");
    endtask

    // Core left runnable so a stray execute would move the PC
    task automatic test_bad_cmd();
        reset_all();
        command(8'h5a, RSP_BAD);
        dump_check();
        end_test("bad_cmd");
    endtask

    initial begin
        for (int k = 0; k < IM_WORDS; k++) begin
            ref_imem[k] = '0;
        end
        test_reset_state();
        test_load();
        test_step();
        test_run();
        test_step_halted();
        test_bad_cmd();
        sva_fails = DUT.debug_unit_1.sva_1.fail_count;
        $display("%0d tests run, %0d failing, %0d check errors, %0d assertion errors",
                 tests_run, tests_bad, errors, sva_fails);
        if (tests_bad == 0 && errors == 0 && sva_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- dv/top_sva.sv
`timescale 1ns/1ps

module top_sva (
    input logic               i_clock,
    input logic               i_rst,
    input logic [7:0]         i_rx_data,
    input logic               i_rx_done,
    input logic               i_tx_done,
    input logic               i_hlt,
    input logic               i_exec,
    input logic               i_tx_start,
    input dbg_pkg::du_state_e i_state
);
    import dbg_pkg::*;

    int   fail_count = 0;
    logic tx_busy;  // Between tx_start and tx_done

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            tx_busy <= 1'b0;
        end else if (i_tx_start) begin
            tx_busy <= 1'b1;
        end else if (i_tx_done) begin
            tx_busy <= 1'b0;
        end
    end

    // No exec on a halted core, nor on the cycle after
    a_no_exec_halted: assert property (@(posedge i_clock) disable iff (i_rst)
        i_hlt |-> !i_exec ##1 !i_exec)
        else begin
            $error("exec raised while the core is halted");
            fail_count++;
        end

    // One execute cycle per step command
    a_step_one_exec: assert property (@(posedge i_clock) disable iff (i_rst)
        (i_state == IDLE && i_rx_done && i_rx_data == CMD_STEP && !i_hlt)
            |=> i_exec ##1 !i_exec)
        else begin
            $error("step command did not give a single exec cycle");
            fail_count++;
        end

    a_no_start_busy: assert property (@(posedge i_clock) disable iff (i_rst)
        tx_busy |-> !i_tx_start)
        else begin
            $error("tx_start raised during a transmission");
            fail_count++;
        end

endmodule

bind debug_unit top_sva sva_1 (
    .i_clock(i_clock),
    .i_rst(i_rst),
    .i_rx_data(i_rx_data),
    .i_rx_done(i_rx_done),
    .i_tx_done(i_tx_done),
    .i_hlt(i_hlt),
    .i_exec(o_exec),
    .i_tx_start(o_tx_start),
    .i_state(o_state)
);

//--- hdl/top.sv
`timescale 1ns/1ps

module top (
    input  logic               i_clock,
    input  logic               i_rst,
    input  logic               i_uart_rx,
    output logic               o_uart_tx,
    output logic               o_hlt,
    output dbg_pkg::du_state_e o_state
);
    import cpu_pkg::*;

    logic [7:0]  rx_data;
    logic        rx_done;
    logic [7:0]  tx_data;
    logic        tx_start;
    logic        tx_done;
    im_wr_s      im_wr;
    dbg_rd_s     dbg_rd;
    logic        exec;
    logic [31:0] pc;
    logic [31:0] rb_data;
    logic [31:0] dm_data;

    uart uart_1 (.i_clock(i_clock),
                 .i_rst(i_rst),
                 .i_rx(i_uart_rx),
                 .i_tx_data(tx_data),
                 .i_tx_start(tx_start),
                 .o_rx_data(rx_data),
                 .o_rx_done(rx_done),
                 .o_tx(o_uart_tx),
                 .o_tx_done(tx_done));

    debug_unit debug_unit_1 (.i_clock(i_clock),
                             .i_rst(i_rst),
                             .i_rx_data(rx_data),
                             .i_rx_done(rx_done),
                             .i_tx_done(tx_done),
                             .i_pc(pc),
                             .i_rb_data(rb_data),
                             .i_dm_data(dm_data),
                             .i_hlt(o_hlt),
                             .o_tx_data(tx_data),
                             .o_tx_start(tx_start),
                             .o_im_wr(im_wr),
                             .o_dbg_rd(dbg_rd),
                             .o_exec(exec),
                             .o_state(o_state));

    data_path data_path_1 (.i_clock(i_clock),
                           .i_rst(i_rst),
                           .i_im_wr(im_wr),
                           .i_exec(exec),  // Step or run enable
                           .i_dbg_rd(dbg_rd),
                           .o_pc(pc),
                           .o_rb_data(rb_data),
                           .o_dm_data(dm_data),
                           .o_hlt(o_hlt));

endmodule

//--- hdl/data_path.sv
`timescale 1ns/1ps

module data_path (
    input  logic             i_clock,
    input  logic             i_rst,
    input  cpu_pkg::im_wr_s  i_im_wr,
    input  logic             i_exec,
    input  cpu_pkg::dbg_rd_s i_dbg_rd,
    output logic [31:0]      o_pc,
    output logic [31:0]      o_rb_data,
    output logic [31:0]      o_dm_data,
    output logic             o_hlt
);
    import cpu_pkg::*;

    logic [31:0] imem [IM_WORDS] = '{default: '0};  // Blank words retire as no-ops
    logic [31:0] regs [NREGS];
    logic [31:0] dmem [DM_WORDS];

    instr_u      instr;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] rd_val;
    logic [31:0] imm_sx;
    logic [31:0] mem_addr;
    logic [31:0] wb_data;
    logic        wb_en;
    logic        dm_we;
    logic        commit;

    always_ff @(posedge i_clock) begin
        if (i_im_wr.en) begin
            imem[i_im_wr.addr[7:2]][i_im_wr.addr[1:0]*8 +: 8] <= i_im_wr.data;
        end
    end

    assign instr    = imem[o_pc[$clog2(IM_WORDS)-1:0]];
    assign o_hlt    = (instr.r.op == OP_HALT);
    assign rs_val   = regs[instr.r.rs];
    assign rt_val   = regs[instr.r.rt];
    assign rd_val   = regs[instr.i.rd];  // Store data for SW
    assign imm_sx   = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign mem_addr = rs_val + imm_sx;
    assign commit   = i_exec && !o_hlt;

    always_comb begin
        wb_en   = 1'b0;
        wb_data = mem_addr;
        dm_we   = 1'b0;
        case (instr.r.op)
            OP_ADD: begin
                wb_en   = 1'b1;
                wb_data = rs_val + rt_val;
            end
            OP_SUB: begin
                wb_en   = 1'b1;
                wb_data = rs_val - rt_val;
            end
            OP_ADDI: wb_en = 1'b1;
            OP_LW: begin
                wb_en   = 1'b1;
                wb_data = dmem[mem_addr[$clog2(DM_WORDS)-1:0]];
            end
            OP_SW:   dm_we = 1'b1;
            default: wb_en = 1'b0;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_pc <= '0;
            for (int k = 0; k < NREGS; k++) begin
                regs[k] <= '0;
            end
            for (int k = 0; k < DM_WORDS; k++) begin
                dmem[k] <= '0;
            end
        end else if (commit) begin
            o_pc <= o_pc + 32'd1;  // Word addressed
            if (wb_en) begin
                regs[instr.r.rd] <= wb_data;
            end
            if (dm_we) begin
                dmem[mem_addr[$clog2(DM_WORDS)-1:0]] <= rd_val;
            end
        end
    end

    assign o_rb_data = regs[i_dbg_rd.rb_addr];
    assign o_dm_data = dmem[i_dbg_rd.dm_addr];

endmodule

//--- hdl/debug_unit.sv
`timescale 1ns/1ps

module debug_unit (
    input  logic               i_clock,
    input  logic               i_rst,
    input  logic [7:0]         i_rx_data,
    input  logic               i_rx_done,
    input  logic               i_tx_done,
    input  logic [31:0]        i_pc,
    input  logic [31:0]        i_rb_data,
    input  logic [31:0]        i_dm_data,
    input  logic               i_hlt,
    output logic [7:0]         o_tx_data,
    output logic               o_tx_start,
    output cpu_pkg::im_wr_s    o_im_wr,
    output cpu_pkg::dbg_rd_s   o_dbg_rd,
    output logic               o_exec,
    output dbg_pkg::du_state_e o_state
);
    import dbg_pkg::*;
    import cpu_pkg::*;

    du_state_e                     state;
    logic [7:0]                    byte_addr;
    logic [7:0]                    load_left;
    logic [$clog2(DUMP_WORDS)-1:0] word_idx;
    logic [1:0]                    byte_idx;
    logic                          dump_busy;  // Byte sent, waiting for tx_done
    logic [31:0]                   dump_word;
    logic [7:0]                    dump_byte;

    assign o_state = state;
    assign o_exec  = ((state == STEP) || (state == RUN)) && !i_hlt;

    // Word 0 is the PC, then registers, then data memory
    always_comb begin
        o_dbg_rd.rb_addr = 3'(word_idx - 1);
        o_dbg_rd.dm_addr = 3'(word_idx - (NREGS + 1));
        if (word_idx == 0) begin
            dump_word = i_pc;
        end else if (word_idx <= NREGS) begin
            dump_word = i_rb_data;
        end else begin
            dump_word = i_dm_data;
        end
    end

    assign dump_byte = dump_word[byte_idx*8 +: 8];  // Little endian

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state      <= IDLE;
            o_tx_start <= 1'b0;
            o_im_wr.en <= 1'b0;
            byte_addr  <= '0;
            load_left  <= '0;
            word_idx   <= '0;
            byte_idx   <= '0;
            dump_busy  <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            o_im_wr.en <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_rx_done) begin
                        case (i_rx_data)
                            CMD_LOAD: begin
                                byte_addr <= '0;
                                state     <= LOAD_CNT;
                            end
                            CMD_STEP: state <= STEP;
                            CMD_RUN:  state <= RUN;
                            CMD_DUMP: begin
                                word_idx  <= '0;
                                byte_idx  <= '0;
                                dump_busy <= 1'b0;
                                state     <= DUMP;
                            end
                            default: begin
                                o_tx_data  <= RSP_BAD;
                                o_tx_start <= 1'b1;
                                state      <= REPLY;
                            end
                        endcase
                    end
                end
                LOAD_CNT: begin
                    if (i_rx_done) begin
                        load_left <= i_rx_data;
                        if (i_rx_data == 8'd0) begin  // Empty load
                            o_tx_data  <= RSP_OK;
                            o_tx_start <= 1'b1;
                            state      <= REPLY;
                        end else begin
                            state <= LOAD_BYTE;
                        end
                    end
                end
                LOAD_BYTE: begin
                    if (i_rx_done) begin
                        o_im_wr.en   <= 1'b1;
                        o_im_wr.addr <= byte_addr;
                        o_im_wr.data <= i_rx_data;
                        byte_addr    <= byte_addr + 1'b1;
                        load_left    <= load_left - 1'b1;
                        if (load_left == 8'd1) begin
                            o_tx_data  <= RSP_OK;
                            o_tx_start <= 1'b1;
                            state      <= REPLY;
                        end
                    end
                end
                STEP: begin
                    o_tx_data  <= RSP_OK;
                    o_tx_start <= 1'b1;
                    state      <= REPLY;
                end
                RUN: begin
                    if (i_hlt) begin
                        o_tx_data  <= RSP_HALT;
                        o_tx_start <= 1'b1;
                        state      <= REPLY;
                    end
                end
                REPLY: begin
                    if (i_tx_done) begin
                        state <= IDLE;
                    end
                end
                DUMP: begin
                    if (!dump_busy) begin
                        o_tx_data  <= dump_byte;
                        o_tx_start <= 1'b1;
                        dump_busy  <= 1'b1;
                    end else if (i_tx_done) begin
                        dump_busy <= 1'b0;
                        byte_idx  <= byte_idx + 1'b1;
                        if (byte_idx == 2'd3) begin
                            word_idx <= word_idx + 1'b1;
                            if (word_idx == DUMP_WORDS - 1) begin
                                state <= IDLE;
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- hdl/uart.sv
`timescale 1ns/1ps

module uart (
    input  logic       i_clock,
    input  logic       i_rst,
    input  logic       i_rx,
    input  logic [7:0] i_tx_data,
    input  logic       i_tx_start,
    output logic [7:0] o_rx_data,
    output logic       o_rx_done,
    output logic       o_tx,
    output logic       o_tx_done
);
    import dbg_pkg::*;

    enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state;
    enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state;

    logic [2:0]                      rx_sync;  // Two sync stages and the previous sample
    logic [$clog2(CLKS_PER_BIT)-1:0] rx_cnt;
    logic [$clog2(CLKS_PER_BIT)-1:0] tx_cnt;
    logic [2:0]                      rx_bit;
    logic [2:0]                      tx_bit;
    logic [7:0]                      tx_shift;
    logic                            rx_s;
    logic                            rx_fall;
    logic                            rx_bit_end;
    logic                            tx_bit_end;

    assign rx_s       = rx_sync[1];
    assign rx_fall    = rx_sync[2] && !rx_sync[1];
    assign rx_bit_end = (rx_cnt == CLKS_PER_BIT - 1);
    assign tx_bit_end = (tx_cnt == CLKS_PER_BIT - 1);

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            rx_sync   <= '1;
            rx_state  <= RX_IDLE;
            rx_cnt    <= '0;
            rx_bit    <= '0;
            o_rx_done <= 1'b0;
        end else begin
            rx_sync   <= {rx_sync[1:0], i_rx};
            o_rx_done <= 1'b0;
            rx_cnt    <= rx_cnt + 1'b1;
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (rx_fall) begin
                        rx_state <= RX_START;
                    end
                end
                RX_START: begin
                    if (rx_cnt == CLKS_PER_BIT / 2 - 1) begin  // Middle of start bit
                        rx_cnt   <= '0;
                        rx_bit   <= '0;
                        rx_state <= rx_s ? RX_IDLE : RX_DATA;  // Line back high, a glitch
                    end
                end
                RX_DATA: begin
                    if (rx_bit_end) begin
                        rx_cnt    <= '0;
                        o_rx_data <= {rx_s, o_rx_data[7:1]};  // LSB first
                        rx_bit    <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (rx_bit_end) begin
                        o_rx_done <= 1'b1;
                        rx_state  <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            tx_state  <= TX_IDLE;
            tx_cnt    <= '0;
            tx_bit    <= '0;
            o_tx      <= 1'b1;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            tx_cnt    <= tx_cnt + 1'b1;
            case (tx_state)
                TX_IDLE: begin
                    tx_cnt <= '0;
                    o_tx   <= 1'b1;
                    if (i_tx_start) begin
                        tx_shift <= i_tx_data;
                        o_tx     <= 1'b0;
                        tx_state <= TX_START;
                    end
                end
                TX_START: begin
                    if (tx_bit_end) begin
                        tx_cnt   <= '0;
                        tx_bit   <= '0;
                        o_tx     <= tx_shift[0];
                        tx_state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (tx_bit_end) begin
                        tx_cnt   <= '0;
                        tx_shift <= tx_shift >> 1;
                        tx_bit   <= tx_bit + 1'b1;
                        if (tx_bit == 3'd7) begin
                            o_tx     <= 1'b1;  // Stop bit
                            tx_state <= TX_STOP;
                        end else begin
                            o_tx <= tx_shift[1];
                        end
                    end
                end
                default: begin
                    if (tx_bit_end) begin
                        o_tx_done <= 1'b1;
                        tx_state  <= TX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- hdl/cpu_pkg.sv
package cpu_pkg;

    localparam int IM_WORDS = 64;
    localparam int NREGS    = 8;
    localparam int DM_WORDS = 8;

    localparam logic [3:0] OP_ADD  = 4'h1;
    localparam logic [3:0] OP_SUB  = 4'h2;
    localparam logic [3:0] OP_ADDI = 4'h3;
    localparam logic [3:0] OP_LW   = 4'h4;
    localparam logic [3:0] OP_SW   = 4'h5;
    localparam logic [3:0] OP_HALT = 4'hf;  // All other codes retire as no-ops

    // Register form, rd = rs op rt
    typedef struct packed {
        logic [3:0]  op;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [2:0]  rt;
        logic [18:0] unused;
    } instr_r_s;

    // Immediate form, imm is sign extended
    typedef struct packed {
        logic [3:0]  op;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [5:0]  unused;
        logic [15:0] imm;
    } instr_i_s;

    typedef union packed {
        instr_r_s r;
        instr_i_s i;
    } instr_u;

    // Loader byte write into instruction memory
    typedef struct packed {
        logic       en;
        logic [7:0] addr;  // Byte address, little endian within a word
        logic [7:0] data;
    } im_wr_s;

    typedef struct packed {
        logic [2:0] rb_addr;
        logic [2:0] dm_addr;
    } dbg_rd_s;

endpackage

//--- hdl/dbg_pkg.sv
package dbg_pkg;

    // UART bit time in system clocks
    localparam int CLKS_PER_BIT = 16;

    // PC, then the register file, then data memory
    localparam int DUMP_WORDS = 17;

    // Host commands
    localparam logic [7:0] CMD_LOAD = 8'h4c;  // 'L'
    localparam logic [7:0] CMD_STEP = 8'h53;  // 'S'
    localparam logic [7:0] CMD_RUN  = 8'h52;  // 'R'
    localparam logic [7:0] CMD_DUMP = 8'h44;  // 'D'

    // Replies
    localparam logic [7:0] RSP_OK   = 8'h4b;  // 'K'
    localparam logic [7:0] RSP_HALT = 8'h48;  // 'H'
    localparam logic [7:0] RSP_BAD  = 8'h3f;  // '?'

    typedef enum logic [2:0] {
        IDLE,
        LOAD_CNT,   // Waiting for the byte count
        LOAD_BYTE,
        STEP,       // Single execute cycle
        RUN,
        REPLY,      // One reply byte in flight
        DUMP
    } du_state_e;

endpackage
